// File: lane_pkg.sv
package lane_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths and pipeline depths
   //////////////////////////////////////////////////////////////////////
   localparam int WORD_W         = 32;
   localparam int BYTES_PER_WORD = 4;
   localparam int ALU_CTRL_W     = 6;

   // Read request to operands at the ALU
   localparam int READ_DELAY = 2;
   // Write command to register file write
   localparam int WB_DELAY   = 2;

   //////////////////////////////////////////////////////////////////////
   // Selector codes
   //////////////////////////////////////////////////////////////////////
   // Element width, code 3 decodes as a full word too
   typedef enum logic [1:0] {
      BYTE = 2'd0,
      HALF = 2'd1,
      WORD = 2'd2
   } width_e;

   // Write-back data source
   typedef enum logic {
      SRC_ALU  = 1'b0,
      SRC_LOAD = 1'b1
   } wsrc_e;

   // One register word seen as bytes or as halfwords
   typedef union packed {
      logic [BYTES_PER_WORD-1:0][7:0] bytes;
      logic [1:0][15:0]               halves;
   } lane_word_t;

endpackage

// File: lane_wb_if.sv
interface lane_wb_if import lane_pkg::*; #(
   parameter int W_PORTS    = 2,
   parameter int VRF_DEPTH  = 64,
   parameter int MASK_DEPTH = 32
);

   // VRF write side, one entry per lane
   logic [W_PORTS-1:0][$clog2(VRF_DEPTH)-1:0]  waddr;
   logic [W_PORTS-1:0][WORD_W-1:0]             wdata;
   logic [W_PORTS-1:0][BYTES_PER_WORD-1:0]     bwen;

   // Mask file write side
   logic [W_PORTS-1:0][$clog2(MASK_DEPTH)-1:0] mask_waddr;
   logic [W_PORTS-1:0]                         mask_wen;
   logic [W_PORTS-1:0]                         mask_wdata;

   modport wb (
      output waddr, wdata, bwen,
      output mask_waddr, mask_wen, mask_wdata
   );

   modport vrf (input waddr, wdata, bwen);

   modport mask (input mask_waddr, mask_wen, mask_wdata);

endinterface

// File: vrf_bank.sv
module vrf_bank import lane_pkg::*; #(
   parameter int R_PORTS   = 4,
   parameter int W_PORTS   = 2,
   parameter int VRF_DEPTH = 64
) (
   input  logic                                      clk_i,
   input  logic                                      rst_i,

   input  logic [R_PORTS-1:0]                        ren_i,
   input  logic [R_PORTS-1:0][$clog2(VRF_DEPTH)-1:0] raddr_i,
   output logic [R_PORTS-1:0][WORD_W-1:0]            rdata_o,

   lane_wb_if.vrf                                    wb
);

   localparam int BYTE_W = WORD_W / BYTES_PER_WORD;

   logic [WORD_W-1:0] mem [VRF_DEPTH];

   //////////////////////////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////////////////////////
   // Lanes are walked in order so the higher lane wins on a collision
   always_ff @(posedge clk_i) begin
      for (int l = 0; l < W_PORTS; l++) begin
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (wb.bwen[l][b]) begin
               mem[wb.waddr[l]][b*BYTE_W +: BYTE_W] <= wb.wdata[l][b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////////////////////////
   // Disabled port keeps its last word
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rdata_o <= '0;
      end else begin
         for (int p = 0; p < R_PORTS; p++) begin
            if (ren_i[p]) begin
               rdata_o[p] <= mem[raddr_i[p]];
            end
         end
      end
   end

endmodule

// File: element_extract.sv
module element_extract import lane_pkg::*; #(
   parameter int R_PORTS = 4
) (
   input  logic                           clk_i,
   input  logic                           rst_i,

   input  logic [R_PORTS-1:0][WORD_W-1:0] rdata_i,
   input  logic [R_PORTS-1:0][1:0]        el_index_i,
   input  width_e [R_PORTS/2-1:0]         width_i,
   output logic [R_PORTS-1:0][WORD_W-1:0] elem_o
);

   // Index and width aligned with the registered read word
   logic [R_PORTS-1:0][1:0]        idx_q;
   width_e [R_PORTS/2-1:0]         width_q;
   logic [R_PORTS-1:0][WORD_W-1:0] elem_d;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         idx_q <= '0;
         for (int l = 0; l < R_PORTS / 2; l++) begin
            width_q[l] <= BYTE;
         end
      end else begin
         idx_q   <= el_index_i;
         width_q <= width_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Element select
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      lane_word_t word;
      for (int p = 0; p < R_PORTS; p++) begin
         word = lane_word_t'(rdata_i[p]);
         // Ports 2k and 2k+1 follow the width of lane k
         case (width_q[p / 2])
            BYTE: begin
               elem_d[p] = WORD_W'(word.bytes[idx_q[p]]);
            end
            HALF: begin
               elem_d[p] = WORD_W'(word.halves[idx_q[p][0]]);
            end
            default: begin
               elem_d[p] = rdata_i[p];
            end
         endcase
      end
   end

   // Operand register in front of the ALU
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         elem_o <= '0;
      end else begin
         elem_o <= elem_d;
      end
   end

endmodule

// File: mask_regfile.sv
module mask_regfile import lane_pkg::*; #(
   parameter int W_PORTS    = 2,
   parameter int MASK_DEPTH = 32
) (
   input  logic                                       clk_i,
   input  logic                                       rst_i,

   input  logic [W_PORTS-1:0][$clog2(MASK_DEPTH)-1:0] raddr_i,
   output logic [W_PORTS-1:0]                         rbit_o,

   lane_wb_if.mask                                    wb
);

   // One bit per element
   logic [MASK_DEPTH-1:0] mask_mem;

   // Read pipeline, stage 0 is the fresh read
   logic [WB_DELAY-1:0][W_PORTS-1:0] rd_pipe;

   always_ff @(posedge clk_i) begin
      for (int l = 0; l < W_PORTS; l++) begin
         if (wb.mask_wen[l]) begin
            mask_mem[wb.mask_waddr[l]] <= wb.mask_wdata[l];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rd_pipe <= '0;
      end else begin
         for (int l = 0; l < W_PORTS; l++) begin
            rd_pipe[0][l] <= mask_mem[raddr_i[l]];
         end
         for (int s = 1; s < WB_DELAY; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
         end
      end
   end

   // Lines up with the write command at the last write-back stage
   assign rbit_o = rd_pipe[WB_DELAY-1];

endmodule

// File: writeback_stage.sv
module writeback_stage import lane_pkg::*; #(
   parameter int W_PORTS    = 2,
   parameter int VRF_DEPTH  = 64,
   parameter int MASK_DEPTH = 32
) (
   input  logic                                       clk_i,
   input  logic                                       rst_i,

   // Write command, per lane
   input  logic [W_PORTS-1:0][$clog2(VRF_DEPTH)-1:0]  waddr_i,
   input  logic [W_PORTS-1:0][BYTES_PER_WORD-1:0]     bwen_i,
   input  wsrc_e [W_PORTS-1:0]                        wsrc_i,
   input  logic [W_PORTS-1:0]                         vector_mask_i,
   input  logic [W_PORTS-1:0][$clog2(MASK_DEPTH)-1:0] mask_addr_i,
   input  logic [W_PORTS-1:0]                         mask_wen_i,
   input  logic [W_PORTS-1:0]                         request_load_i,

   // ALU result, per lane
   input  logic [W_PORTS-1:0]                         alu_vld_i,
   input  logic [W_PORTS-1:0][WORD_W-1:0]             alu_res_i,
   input  logic [W_PORTS-1:0]                         alu_mask_i,

   input  logic [WORD_W-1:0]                          load_data_i,
   input  logic [W_PORTS-1:0]                         mask_bit_i,

   lane_wb_if.wb                                      wb
);

   localparam int AW  = $clog2(VRF_DEPTH);
   localparam int MAW = $clog2(MASK_DEPTH);
   localparam int L   = WB_DELAY - 1;

   logic [W_PORTS-1:0][WORD_W-1:0] wdata_sel;

   // Command pipeline, index 0 is the newest stage
   logic [WB_DELAY-1:0][W_PORTS-1:0][AW-1:0]             waddr_q;
   logic [WB_DELAY-1:0][W_PORTS-1:0][WORD_W-1:0]         wdata_q;
   logic [WB_DELAY-1:0][W_PORTS-1:0][BYTES_PER_WORD-1:0] bwen_q;
   logic [WB_DELAY-1:0][W_PORTS-1:0]                     vm_q;
   logic [WB_DELAY-1:0][W_PORTS-1:0][MAW-1:0]            maddr_q;
   logic [WB_DELAY-1:0][W_PORTS-1:0]                     mwen_q;
   logic [WB_DELAY-1:0][W_PORTS-1:0]                     mdata_q;
   logic [WB_DELAY-1:0][W_PORTS-1:0]                     qual_q;

   // Data source picked at issue
   always_comb begin
      for (int l = 0; l < W_PORTS; l++) begin
         wdata_sel[l] = (wsrc_i[l] == SRC_LOAD) ? load_data_i : alu_res_i[l];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         waddr_q <= '0;
         wdata_q <= '0;
         bwen_q  <= '0;
         vm_q    <= '0;
         maddr_q <= '0;
         mwen_q  <= '0;
         mdata_q <= '0;
         qual_q  <= '0;
      end else begin
         waddr_q <= {waddr_q[WB_DELAY-2:0], waddr_i};
         wdata_q <= {wdata_q[WB_DELAY-2:0], wdata_sel};
         bwen_q  <= {bwen_q[WB_DELAY-2:0], bwen_i};
         vm_q    <= {vm_q[WB_DELAY-2:0], vector_mask_i};
         maddr_q <= {maddr_q[WB_DELAY-2:0], mask_addr_i};
         mwen_q  <= {mwen_q[WB_DELAY-2:0], mask_wen_i};
         mdata_q <= {mdata_q[WB_DELAY-2:0], alu_mask_i};
         qual_q  <= {qual_q[WB_DELAY-2:0], alu_vld_i | request_load_i};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Last stage, masking and qualification
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      for (int l = 0; l < W_PORTS; l++) begin
         wb.waddr[l]      = waddr_q[L][l];
         wb.wdata[l]      = wdata_q[L][l];
         // Masked lane needs its mask bit set to write
         wb.bwen[l]       = bwen_q[L][l]
                            & {BYTES_PER_WORD{qual_q[L][l] & (~vm_q[L][l] | mask_bit_i[l])}};
         wb.mask_waddr[l] = maddr_q[L][l];
         wb.mask_wen[l]   = mwen_q[L][l] & qual_q[L][l];
         wb.mask_wdata[l] = mdata_q[L][l];
      end
   end

endmodule

// File: vector_lane.sv
module vector_lane import lane_pkg::*; #(
   parameter int R_PORTS    = 4,
   parameter int W_PORTS    = 2,
   parameter int VRF_DEPTH  = 64,
   parameter int MASK_DEPTH = 32
) (
   input  logic                                       clk_i,
   input  logic                                       rst_i,

   // Read requests
   input  logic [R_PORTS-1:0]                         vrf_ren_i,
   input  logic [R_PORTS-1:0][$clog2(VRF_DEPTH)-1:0]  vrf_raddr_i,
   input  logic [R_PORTS-1:0][1:0]                    el_index_i,
   input  width_e [W_PORTS-1:0]                       read_width_i,
   input  logic [W_PORTS-1:0]                         read_valid_i,
   input  logic [W_PORTS-1:0][ALU_CTRL_W-1:0]         alu_ctrl_i,

   // Write commands
   input  logic [W_PORTS-1:0][$clog2(VRF_DEPTH)-1:0]  vrf_waddr_i,
   input  logic [W_PORTS-1:0][BYTES_PER_WORD-1:0]     vrf_bwen_i,
   input  wsrc_e [W_PORTS-1:0]                        wsrc_i,
   input  logic [W_PORTS-1:0]                         vector_mask_i,
   input  logic [W_PORTS-1:0][$clog2(MASK_DEPTH)-1:0] mask_addr_i,
   input  logic [W_PORTS-1:0]                         mask_wen_i,
   input  logic [W_PORTS-1:0]                         request_load_i,
   input  logic [WORD_W-1:0]                          load_data_i,

   // ALU interface
   input  logic [W_PORTS-1:0]                         alu_vld_i,
   input  logic [W_PORTS-1:0][WORD_W-1:0]             alu_res_i,
   input  logic [W_PORTS-1:0]                         alu_mask_i,
   output logic [W_PORTS-1:0][WORD_W-1:0]             vs1_data_o,
   output logic [W_PORTS-1:0][WORD_W-1:0]             vs2_data_o,
   output logic [W_PORTS-1:0]                         alu_vld_o,
   output logic [W_PORTS-1:0][ALU_CTRL_W-1:0]         alu_opmode_o
);

   logic [R_PORTS-1:0][WORD_W-1:0] vrf_rdata;
   logic [R_PORTS-1:0][WORD_W-1:0] elem;
   logic [W_PORTS-1:0]             mask_bit;

   // Operand-side control, delayed to meet the operands
   logic [READ_DELAY-1:0][W_PORTS-1:0]                 rvld_q;
   logic [READ_DELAY-1:0][W_PORTS-1:0][ALU_CTRL_W-1:0] ctrl_q;

   lane_wb_if #(
      .W_PORTS   (W_PORTS),
      .VRF_DEPTH (VRF_DEPTH),
      .MASK_DEPTH(MASK_DEPTH)
   ) wb_if ();

   //////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////
   vrf_bank #(
      .R_PORTS  (R_PORTS),
      .W_PORTS  (W_PORTS),
      .VRF_DEPTH(VRF_DEPTH)
   ) vrf_bank_i (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .ren_i  (vrf_ren_i),
      .raddr_i(vrf_raddr_i),
      .rdata_o(vrf_rdata),
      .wb     (wb_if.vrf)
   );

   element_extract #(
      .R_PORTS(R_PORTS)
   ) element_extract_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .rdata_i   (vrf_rdata),
      .el_index_i(el_index_i),
      .width_i   (read_width_i),
      .elem_o    (elem)
   );

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rvld_q <= '0;
         ctrl_q <= '0;
      end else begin
         rvld_q <= {rvld_q[READ_DELAY-2:0], read_valid_i};
         ctrl_q <= {ctrl_q[READ_DELAY-2:0], alu_ctrl_i};
      end
   end

   // Lane k takes its operands from ports 2k and 2k+1
   always_comb begin
      for (int k = 0; k < W_PORTS; k++) begin
         vs1_data_o[k] = elem[2*k];
         vs2_data_o[k] = elem[2*k+1];
      end
   end

   assign alu_vld_o    = rvld_q[READ_DELAY-1];
   assign alu_opmode_o = ctrl_q[READ_DELAY-1];

   //////////////////////////////////////////////////////////////////////
   // Write path
   //////////////////////////////////////////////////////////////////////
   mask_regfile #(
      .W_PORTS   (W_PORTS),
      .MASK_DEPTH(MASK_DEPTH)
   ) mask_regfile_i (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .raddr_i(mask_addr_i),
      .rbit_o (mask_bit),
      .wb     (wb_if.mask)
   );

   writeback_stage #(
      .W_PORTS   (W_PORTS),
      .VRF_DEPTH (VRF_DEPTH),
      .MASK_DEPTH(MASK_DEPTH)
   ) writeback_stage_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .waddr_i       (vrf_waddr_i),
      .bwen_i        (vrf_bwen_i),
      .wsrc_i        (wsrc_i),
      .vector_mask_i (vector_mask_i),
      .mask_addr_i   (mask_addr_i),
      .mask_wen_i    (mask_wen_i),
      .request_load_i(request_load_i),
      .alu_vld_i     (alu_vld_i),
      .alu_res_i     (alu_res_i),
      .alu_mask_i    (alu_mask_i),
      .load_data_i   (load_data_i),
      .mask_bit_i    (mask_bit),
      .wb            (wb_if.wb)
   );

endmodule

// File: vector_lane_assertions.sv
module vector_lane_assertions import lane_pkg::*; #(
   parameter int R_PORTS    = 4,
   parameter int W_PORTS    = 2,
   parameter int VRF_DEPTH  = 64,
   parameter int MASK_DEPTH = 32
) (
   input logic                                       clk_i,
   input logic                                       rst_i,
   input logic [R_PORTS-1:0]                         ren_i,
   input logic [R_PORTS-1:0][$clog2(VRF_DEPTH)-1:0]  raddr_i,
   input logic [R_PORTS-1:0][1:0]                    idx_i,
   input logic [W_PORTS-1:0][1:0]                    width_i,
   input logic [W_PORTS-1:0]                         rvalid_i,
   input logic [W_PORTS-1:0][ALU_CTRL_W-1:0]         ctrl_i,
   input logic [W_PORTS-1:0][$clog2(VRF_DEPTH)-1:0]  waddr_i,
   input logic [W_PORTS-1:0][BYTES_PER_WORD-1:0]     bwen_i,
   input logic [W_PORTS-1:0]                         wsrc_i,
   input logic [W_PORTS-1:0]                         vmask_i,
   input logic [W_PORTS-1:0][$clog2(MASK_DEPTH)-1:0] maddr_i,
   input logic [W_PORTS-1:0]                         mwen_i,
   input logic [W_PORTS-1:0]                         load_i,
   input logic [WORD_W-1:0]                          load_data_i,
   input logic [W_PORTS-1:0]                         alu_vld_i,
   input logic [W_PORTS-1:0][WORD_W-1:0]             alu_res_i,
   input logic [W_PORTS-1:0]                         alu_mask_i,
   input logic [W_PORTS-1:0][WORD_W-1:0]             vs1_i,
   input logic [W_PORTS-1:0][WORD_W-1:0]             vs2_i,
   input logic [W_PORTS-1:0]                         vld_i,
   input logic [W_PORTS-1:0][ALU_CTRL_W-1:0]         opmode_i
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int AW  = $clog2(VRF_DEPTH);
   localparam int MAW = $clog2(MASK_DEPTH);
   localparam int LW  = WB_DELAY - 1;
   localparam int LR  = READ_DELAY - 1;

   int unsigned err_cnt  = 0;
   logic        rst_q    = 1'b0;
   logic        rst_seen = 1'b0;

   // Any read requested since reset, aligned with the operands
   logic [READ_DELAY-1:0] rd_seen;

   // Shadow copies of both register files
   lane_word_t shadow [VRF_DEPTH];
   logic       shadow_mask [MASK_DEPTH];

   // Write commands in flight with enables already qualified
   logic [W_PORTS-1:0][AW-1:0]             w_addr [WB_DELAY];
   logic [W_PORTS-1:0][WORD_W-1:0]         w_data [WB_DELAY];
   logic [W_PORTS-1:0][BYTES_PER_WORD-1:0] w_en   [WB_DELAY];
   logic [W_PORTS-1:0][MAW-1:0]            m_addr [WB_DELAY];
   logic [W_PORTS-1:0]                     m_en   [WB_DELAY];
   logic [W_PORTS-1:0]                     m_data [WB_DELAY];

   // Expected operands in flight
   logic [W_PORTS-1:0][WORD_W-1:0]     e_vs1  [READ_DELAY];
   logic [W_PORTS-1:0][WORD_W-1:0]     e_vs2  [READ_DELAY];
   logic [W_PORTS-1:0]                 e_chk  [READ_DELAY];
   logic [W_PORTS-1:0]                 e_vld  [READ_DELAY];
   logic [W_PORTS-1:0][ALU_CTRL_W-1:0] e_ctrl [READ_DELAY];

   // Zero-extended byte, halfword or whole word of a register
   function automatic logic [WORD_W-1:0] pick(lane_word_t w, logic [1:0] idx, logic [1:0] wd);
      logic [WORD_W-1:0] v;
      v = w;
      if (wd == 2'd0) begin
         return (v >> (8 * idx)) & 32'h0000_00ff;
      end else if (wd == 2'd1) begin
         return (v >> (16 * idx[0])) & 32'h0000_ffff;
      end
      return v;
   endfunction

   always @(posedge clk_i) begin
      rst_q   <= rst_i;
      rd_seen <= {rd_seen[READ_DELAY-2:0], rd_seen[0] | (|ren_i) | (|rvalid_i)};
      for (int s = LW; s > 0; s--) begin
         w_addr[s] <= w_addr[s-1];
         w_data[s] <= w_data[s-1];
         w_en[s]   <= w_en[s-1];
         m_addr[s] <= m_addr[s-1];
         m_en[s]   <= m_en[s-1];
         m_data[s] <= m_data[s-1];
      end
      for (int s = LR; s > 0; s--) begin
         e_vs1[s]  <= e_vs1[s-1];
         e_vs2[s]  <= e_vs2[s-1];
         e_chk[s]  <= e_chk[s-1];
         e_vld[s]  <= e_vld[s-1];
         e_ctrl[s] <= e_ctrl[s-1];
      end
      for (int l = 0; l < W_PORTS; l++) begin
         w_addr[0][l] <= waddr_i[l];
         w_data[0][l] <= wsrc_i[l] ? load_data_i : alu_res_i[l];
         w_en[0][l]   <= bwen_i[l] & {BYTES_PER_WORD{(alu_vld_i[l] | load_i[l])
                         & (~vmask_i[l] | shadow_mask[maddr_i[l]])}};
         m_addr[0][l] <= maddr_i[l];
         m_en[0][l]   <= mwen_i[l] & (alu_vld_i[l] | load_i[l]);
         m_data[0][l] <= alu_mask_i[l];
         e_vs1[0][l]  <= pick(shadow[raddr_i[2*l]], idx_i[2*l], width_i[l]);
         e_vs2[0][l]  <= pick(shadow[raddr_i[2*l+1]], idx_i[2*l+1], width_i[l]);
         e_chk[0][l]  <= rvalid_i[l] & ren_i[2*l] & ren_i[2*l+1];
         e_vld[0][l]  <= rvalid_i[l];
         e_ctrl[0][l] <= ctrl_i[l];
      end
      if (!rst_i) begin
         rst_seen <= 1'b1;
         rd_seen  <= '0;
         w_en[0]  <= '0;
         m_en[0]  <= '0;
         e_chk[0] <= '0;
         e_vld[0] <= '0;
      end
      // Oldest stage lands with the higher lane last
      for (int l = 0; l < W_PORTS; l++) begin
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (w_en[LW][l][b]) begin
               shadow[w_addr[LW][l]].bytes[b] <= w_data[LW][l][8*b +: 8];
            end
         end
         if (m_en[LW][l]) begin
            shadow_mask[m_addr[LW][l]] <= m_data[LW][l];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////
   a_reset: assert property (@(posedge clk_i)
      (rst_seen && !rd_seen[LR]) |-> (vld_i == '0 && vs1_i == '0 && vs2_i == '0))
      else begin
         $error("outputs not cleared between reset and the first read");
         err_cnt++;
      end

   for (genvar k = 0; k < W_PORTS; k++) begin : g_lane
      a_vs1: assert property (@(posedge clk_i) disable iff (!rst_i)
         e_chk[LR][k] |-> vs1_i[k] == e_vs1[LR][k])
         else begin
            $error("MISMATCH vs1 lane %0d: expected %h got %h", k, e_vs1[LR][k], vs1_i[k]);
            err_cnt++;
         end
      a_vs2: assert property (@(posedge clk_i) disable iff (!rst_i)
         e_chk[LR][k] |-> vs2_i[k] == e_vs2[LR][k])
         else begin
            $error("MISMATCH vs2 lane %0d: expected %h got %h", k, e_vs2[LR][k], vs2_i[k]);
            err_cnt++;
         end
      a_vld: assert property (@(posedge clk_i) disable iff (!rst_i)
         vld_i[k] == e_vld[LR][k])
         else begin
            $error("alu valid lane %0d out of step", k);
            err_cnt++;
         end
      a_op: assert property (@(posedge clk_i) disable iff (!rst_i || !rst_q)
         e_vld[LR][k] |-> opmode_i[k] == e_ctrl[LR][k])
         else begin
            $error("MISMATCH opmode lane %0d: expected %h got %h", k, e_ctrl[LR][k],
                   opmode_i[k]);
            err_cnt++;
         end
   end

endmodule

bind vector_lane vector_lane_assertions #(
   .R_PORTS   (R_PORTS),
   .W_PORTS   (W_PORTS),
   .VRF_DEPTH (VRF_DEPTH),
   .MASK_DEPTH(MASK_DEPTH)
) vector_lane_assertions_i (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .ren_i      (vrf_ren_i),
   .raddr_i    (vrf_raddr_i),
   .idx_i      (el_index_i),
   .width_i    (read_width_i),
   .rvalid_i   (read_valid_i),
   .ctrl_i     (alu_ctrl_i),
   .waddr_i    (vrf_waddr_i),
   .bwen_i     (vrf_bwen_i),
   .wsrc_i     (wsrc_i),
   .vmask_i    (vector_mask_i),
   .maddr_i    (mask_addr_i),
   .mwen_i     (mask_wen_i),
   .load_i     (request_load_i),
   .load_data_i(load_data_i),
   .alu_vld_i  (alu_vld_i),
   .alu_res_i  (alu_res_i),
   .alu_mask_i (alu_mask_i),
   .vs1_i      (vs1_data_o),
   .vs2_i      (vs2_data_o),
   .vld_i      (alu_vld_o),
   .opmode_i   (alu_opmode_o)
);

// File: tb_vector_lane.sv
module tb_vector_lane import lane_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic                clk_i = 1'b0;
   logic                rst_i;
   logic [3:0]          vrf_ren_i;
   logic [3:0][5:0]     vrf_raddr_i;
   logic [3:0][1:0]     el_index_i;
   width_e [1:0]        read_width_i;
   logic [1:0]          read_valid_i;
   logic [1:0][5:0]     alu_ctrl_i;
   logic [1:0][5:0]     vrf_waddr_i;
   logic [1:0][3:0]     vrf_bwen_i;
   wsrc_e [1:0]         wsrc_i;
   logic [1:0]          vector_mask_i;
   logic [1:0][4:0]     mask_addr_i;
   logic [1:0]          mask_wen_i;
   logic [1:0]          request_load_i;
   logic [31:0]         load_data_i;
   logic [1:0]          alu_vld_i;
   logic [1:0][31:0]    alu_res_i;
   logic [1:0]          alu_mask_i;
   logic [1:0][31:0]    vs1_data_o;
   logic [1:0][31:0]    vs2_data_o;
   logic [1:0]          alu_vld_o;
   logic [1:0][5:0]     alu_opmode_o;

   integer      seed = 32'h4168;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          timeout_cnt = 0;
   int          err_mark;
   int          to_mark;
   logic [31:0] r1;
   logic [31:0] r2;

   vector_lane #(
      .R_PORTS(4),
      .W_PORTS(2),
      .VRF_DEPTH(64),
      .MASK_DEPTH(32)
   ) vector_lane_i (.*);

   always #4 clk_i = ~clk_i;

   //////////////////////////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////////////////////////
   task automatic write_cmd(input int l, input logic [5:0] addr, input logic [3:0] bwen,
                            input logic from_load, input logic qual, input logic vm,
                            input logic [4:0] maddr, input logic mwen, input logic mbit,
                            input logic [31:0] data);
      @(posedge clk_i);
      request_load_i <= '0;
      alu_vld_i <= '0;
      mask_wen_i <= '0;
      vrf_waddr_i[l] <= addr;
      vrf_bwen_i[l] <= bwen;
      vector_mask_i[l] <= vm;
      mask_addr_i[l] <= maddr;
      mask_wen_i[l] <= mwen;
      alu_mask_i[l] <= mbit;
      if (from_load) begin
         wsrc_i[l] <= SRC_LOAD;
         load_data_i <= data;
         request_load_i[l] <= qual;
      end else begin
         wsrc_i[l] <= SRC_ALU;
         alu_res_i[l] <= data;
         alu_vld_i[l] <= qual;
      end
   endtask

   task automatic settle(input int n);
      @(posedge clk_i);
      request_load_i <= '0;
      alu_vld_i <= '0;
      mask_wen_i <= '0;
      vrf_ren_i <= '0;
      read_valid_i <= '0;
      repeat (n) @(posedge clk_i);
   endtask

   // One operand pair, then wait for it at the ALU
   task automatic read_lane(input int k, input logic [5:0] a1, input logic [5:0] a2,
                            input logic [1:0] i1, input logic [1:0] i2,
                            input logic [1:0] wd, input logic [5:0] ctrl);
      int n;
      @(posedge clk_i);
      vrf_ren_i <= '0;
      read_valid_i <= '0;
      vrf_ren_i[2*k] <= 1'b1;
      vrf_ren_i[2*k+1] <= 1'b1;
      vrf_raddr_i[2*k] <= a1;
      vrf_raddr_i[2*k+1] <= a2;
      el_index_i[2*k] <= i1;
      el_index_i[2*k+1] <= i2;
      read_width_i[k] <= width_e'(wd);
      read_valid_i[k] <= 1'b1;
      alu_ctrl_i[k] <= ctrl;
      @(posedge clk_i);
      vrf_ren_i <= '0;
      read_valid_i <= '0;
      n = 0;
      while (n < 8) begin
         @(negedge clk_i);
         if (alu_vld_o[k]) break;
         n++;
      end
      if (n == 8) begin
         $display("Timed out waiting for operands on lane %0d", k);
         timeout_cnt++;
      end
   endtask

   task automatic report_test(input string name);
      int errs;
      int tos;
      errs = vector_lane_i.vector_lane_assertions_i.err_cnt - err_mark;
      tos = timeout_cnt - to_mark;
      if (errs != 0) begin
         $display("MISMATCH test %s expected 0 assertion failures actual %0d", name, errs);
         fail_cnt++;
      end else if (tos != 0) begin
         $display("Test %s failed: %0d waits timed out", name, tos);
         fail_cnt++;
      end else begin
         $display("Test %s passed", name);
         pass_cnt++;
      end
      err_mark = vector_lane_i.vector_lane_assertions_i.err_cnt;
      to_mark = timeout_cnt;
   endtask

   initial begin
      rst_i = 1'b0;
      vrf_ren_i = '0;
      vrf_raddr_i = '0;
      el_index_i = '0;
      read_width_i = {WORD, WORD};
      read_valid_i = '0;
      alu_ctrl_i = '0;
      vrf_waddr_i = '0;
      vrf_bwen_i = '0;
      wsrc_i = {SRC_ALU, SRC_ALU};
      vector_mask_i = '0;
      mask_addr_i = '0;
      mask_wen_i = '0;
      request_load_i = '0;
      load_data_i = '0;
      alu_vld_i = '0;
      alu_res_i = '0;
      alu_mask_i = '0;
      err_mark = 0;
      to_mark = 0;

      repeat (5) @(posedge clk_i);
      rst_i <= 1'b1;
      settle(3);
      report_test("reset");

      // Fill the whole VRF through the load path
      for (int a = 0; a < 64; a++) begin
         write_cmd(a % 2, a, 4'hf, 1'b1, 1'b1, 1'b0, '0, 1'b0, 1'b0, $random(seed));
      end
      settle(WB_DELAY + 1);
      for (int i = 0; i < 16; i++) begin
         r1 = $random(seed);
         read_lane(i % 2, r1[5:0], r1[13:8], 2'd0, 2'd0, 2'd2, r1[21:16]);
      end
      report_test("load_word");

      for (int wd = 0; wd < 4; wd++) begin
         for (int idx = 0; idx < 4; idx++) begin
            r1 = $random(seed);
            read_lane(idx % 2, r1[5:0], r1[13:8], idx, 3 - idx, wd, r1[21:16]);
         end
      end
      report_test("extract");

      // Partial ALU writes, then commands that carry no valid
      for (int i = 0; i < 20; i++) begin
         r1 = $random(seed);
         r2 = $random(seed);
         write_cmd(i % 2, i, r1[3:0], 1'b0, i < 16, 1'b0, '0, 1'b0, 1'b0, r2);
      end
      settle(WB_DELAY + 1);
      for (int i = 0; i < 20; i += 2) begin
         read_lane((i / 2) % 2, i, i + 1, 2'd0, 2'd0, 2'd2, i);
      end
      report_test("partial_write");

      for (int m = 0; m < 8; m++) begin
         write_cmd(m % 2, '0, 4'h0, 1'b0, 1'b1, 1'b0, m, 1'b1, m % 2, '0);
      end
      settle(WB_DELAY + 1);
      for (int m = 0; m < 8; m++) begin
         write_cmd(m % 2, 32 + m, 4'hf, 1'b0, 1'b1, 1'b1, m, 1'b0, 1'b0, $random(seed));
      end
      settle(WB_DELAY + 1);
      for (int m = 0; m < 8; m += 2) begin
         read_lane((m / 2) % 2, 32 + m, 33 + m, 2'd0, 2'd0, 2'd2, m);
      end
      report_test("masking");

      settle(2);
      $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: vector_lane.f
lane_pkg.sv
lane_wb_if.sv
vrf_bank.sv
element_extract.sv
mask_regfile.sv
writeback_stage.sv
vector_lane.sv
vector_lane_assertions.sv
tb_vector_lane.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_vector_lane \
   -f vector_lane.f \
   -o sim_vector_lane

./obj_dir/sim_vector_lane | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
   exit 0
fi
exit 1
